// ==== verilog.f ====
+incdir+src
src/rv_pkg.sv
src/rv_fetch.sv
src/rv_regfile.sv
src/rv_decode.sv
src/rv_execute.sv
src/rv_memstage.sv
src/rv_hazard.sv
src/rv_core.sv
tests/rv_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the rv_core testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module rv_core_tb -f verilog.f -o rv_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/rv_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1

// ==== tests/rv_core_tb.sv ====
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_core_tb
    import rv_pkg::*;
();

    localparam int    WB_TIMEOUT = 50;  // Cycles allowed between two register writes
    localparam int    QUIET_CYCLES = 12;
    localparam word_t NOP = {12'd0, 5'd0, 3'd0, 5'd0, `OP_ITYPE};

    logic      clk;
    logic      rst;
    word_t     imem_addr;
    word_t     imem_data;
    logic      wb_valid;
    reg_addr_t wb_rd;
    word_t     wb_data;

    word_t     imem [256];
    word_t     prog [$];
    reg_addr_t exp_rd [$];
    word_t     exp_data [$];
    word_t     lcg_state = 32'hb7c9;

    rv_core dut_i (
        .clk       (clk),
        .rst       (rst),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .wb_valid  (wb_valid),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data)
    );

    // Program store answers in the same cycle
    assign imem_data = (imem_addr < 32'd1024) ? imem[imem_addr[9:2]] : NOP;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic word_t next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [2:0] funct3_of(input alu_op_e op);
        case (op)
            ALU_SLT: return 3'b010;
            ALU_OR:  return 3'b110;
            ALU_AND: return 3'b111;
            default: return 3'b000;
        endcase
    endfunction

    function automatic word_t reg_instr(input alu_op_e op, input int rd, input int rs1,
                                        input int rs2);
        logic [6:0] funct7;
        funct7 = (op == ALU_SUB) ? 7'b0100000 : 7'b0000000;
        return {funct7, reg_addr_t'(rs2), reg_addr_t'(rs1), funct3_of(op), reg_addr_t'(rd),
                `OP_RTYPE};
    endfunction

    function automatic word_t imm_instr(input alu_op_e op, input int rd, input int rs1,
                                        input int imm);
        return {12'(imm), reg_addr_t'(rs1), funct3_of(op), reg_addr_t'(rd), `OP_ITYPE};
    endfunction

    function automatic word_t lw_instr(input int rd, input int rs1, input int imm);
        return {12'(imm), reg_addr_t'(rs1), 3'b010, reg_addr_t'(rd), `OP_LOAD};
    endfunction

    function automatic word_t sw_instr(input int rs2, input int rs1, input int imm);
        logic [11:0] i;
        i = 12'(imm);
        return {i[11:5], reg_addr_t'(rs2), reg_addr_t'(rs1), 3'b010, i[4:0], `OP_STORE};
    endfunction

    function automatic word_t beq_instr(input int rs1, input int rs2, input int off);
        logic [12:0] o;
        o = 13'(off);
        return {o[12], o[10:5], reg_addr_t'(rs2), reg_addr_t'(rs1), 3'b000, o[4:1], o[11],
                `OP_BRANCH};
    endfunction

    function automatic word_t jal_instr(input int rd, input int off);
        logic [20:0] o;
        o = 21'(off);
        return {o[20], o[10:1], o[11], o[19:12], reg_addr_t'(rd), `OP_JAL};
    endfunction

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_rd(input reg_addr_t got, input reg_addr_t exp, input string ctx);
        if (got !== exp) begin
            report_error($sformatf("[ERROR] %0t: %s wrote x%0d, expected x%0d",
                                   $time, ctx, got, exp));
        end
    endtask

    task automatic check_data(input word_t got, input word_t exp, input string ctx);
        if (got !== exp) begin
            report_error($sformatf("[ERROR] %0t: %s wrote 0x%08h, expected 0x%08h",
                                   $time, ctx, got, exp));
        end
    endtask

    // Walks prog from PC 0 and lists the architectural writes to x1..x31
    task automatic reference_model();
        word_t regs [32];
        word_t mem_model [word_t];
        word_t pc;
        word_t next_pc;
        word_t ins;
        word_t a;
        word_t b;
        word_t res;
        word_t i_imm;
        word_t s_imm;
        word_t b_imm;
        word_t j_imm;
        logic  writes;
        int    steps;
        exp_rd.delete();
        exp_data.delete();
        foreach (regs[i]) regs[i] = '0;
        pc = '0;
        steps = 0;
        while (pc < word_t'(4 * prog.size()) && steps < 1000) begin
            ins = prog[pc >> 2];
            a = regs[ins[19:15]];
            b = regs[ins[24:20]];
            i_imm = {{20{ins[31]}}, ins[31:20]};
            s_imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            b_imm = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            j_imm = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            writes = 1'b0;
            res = '0;
            next_pc = pc + 32'd4;
            case (ins[6:0])
                `OP_RTYPE, `OP_ITYPE: begin
                    if (ins[6:0] == `OP_ITYPE) begin
                        b = i_imm;
                    end
                    case (ins[14:12])
                        3'b000: begin
                            res = (ins[6:0] == `OP_RTYPE && ins[30]) ? a - b : a + b;
                        end
                        3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        3'b110: res = a | b;
                        3'b111: res = a & b;
                        default: res = a + b;
                    endcase
                    writes = 1'b1;
                end
                `OP_LOAD: begin
                    res = mem_model.exists(a + i_imm) ? mem_model[a + i_imm] : '0;
                    writes = 1'b1;
                end
                `OP_STORE: mem_model[a + s_imm] = b;
                `OP_BRANCH: begin
                    if (a == b) begin
                        next_pc = pc + b_imm;
                    end
                end
                `OP_JAL: begin
                    res = pc + 32'd4;  // Link address
                    writes = 1'b1;
                    next_pc = pc + j_imm;
                end
                default: ;
            endcase
            if (writes && ins[11:7] != 5'd0) begin
                regs[ins[11:7]] = res;
                exp_rd.push_back(ins[11:7]);
                exp_data.push_back(res);
            end
            pc = next_pc;
            steps++;
        end
    endtask

    task automatic wait_wb_event(output reg_addr_t rd, output word_t data);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!wb_valid && cycles < WB_TIMEOUT);
        if (!wb_valid) begin
            report_error($sformatf("Timed out after %0d cycles waiting for a register write",
                                   WB_TIMEOUT));
        end else begin
            rd = wb_rd;
            data = wb_data;
        end
    endtask

    // Reset, load prog, then compare every write in order with the model
    task automatic run_program(input string name);
        reg_addr_t got_rd;
        word_t     got_data;
        reference_model();
        @(negedge clk);
        rst = 1'b1;
        for (int i = 0; i < 256; i++) begin
            imem[i] = (i < prog.size()) ? prog[i] : NOP;
        end
        repeat (8) @(negedge clk);
        rst = 1'b0;
        foreach (exp_rd[i]) begin
            wait_wb_event(got_rd, got_data);
            check_rd(got_rd, exp_rd[i], $sformatf("%s write %0d", name, i));
            check_data(got_data, exp_data[i], $sformatf("%s write %0d", name, i));
        end
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            if (wb_valid) begin
                report_error($sformatf("%s: unexpected extra register write to x%0d",
                                       name, wb_rd));
            end
        end
        $display("%s: %0d register writes compared", name, exp_rd.size());
    endtask

    task automatic alu_forwarding();
        prog.delete();
        prog.push_back(imm_instr(ALU_ADD, 1, 0, 5));
        prog.push_back(imm_instr(ALU_ADD, 2, 1, 3));   // x1 from memory stage
        prog.push_back(reg_instr(ALU_ADD, 3, 1, 2));   // x1 from writeback
        prog.push_back(reg_instr(ALU_SUB, 4, 3, 1));
        prog.push_back(reg_instr(ALU_SLT, 5, 4, 2));
        prog.push_back(reg_instr(ALU_AND, 6, 3, 2));
        prog.push_back(reg_instr(ALU_OR, 7, 6, 5));
        prog.push_back(imm_instr(ALU_ADD, 0, 1, 7));   // No retire event
        prog.push_back(reg_instr(ALU_ADD, 6, 0, 1));
        prog.push_back(imm_instr(ALU_ADD, 1, 0, -9));
        prog.push_back(reg_instr(ALU_SLT, 2, 1, 0));
        prog.push_back(imm_instr(ALU_SLT, 3, 1, -20));
        prog.push_back(imm_instr(ALU_OR, 4, 1, 240));
        prog.push_back(imm_instr(ALU_AND, 5, 4, 255));
        run_program("alu_forwarding");
    endtask

    task automatic load_store_stall();
        prog.delete();
        prog.push_back(imm_instr(ALU_ADD, 1, 0, 64));
        prog.push_back(imm_instr(ALU_ADD, 2, 0, 1445));
        prog.push_back(sw_instr(2, 1, 0));
        prog.push_back(lw_instr(3, 1, 0));
        prog.push_back(reg_instr(ALU_ADD, 4, 3, 3));   // Load-use
        prog.push_back(sw_instr(4, 1, 4));
        prog.push_back(lw_instr(5, 1, 4));
        prog.push_back(imm_instr(ALU_ADD, 6, 5, 1));
        prog.push_back(lw_instr(7, 1, 0));
        prog.push_back(imm_instr(ALU_OR, 1, 0, 3));
        prog.push_back(reg_instr(ALU_SUB, 2, 7, 1));   // Loaded x7 one slot later
        run_program("load_store_stall");
    endtask

    task automatic branch_flush();
        prog.delete();
        prog.push_back(imm_instr(ALU_ADD, 1, 0, 7));
        prog.push_back(imm_instr(ALU_ADD, 2, 0, 7));
        prog.push_back(beq_instr(1, 2, 12));           // Taken so skips two
        prog.push_back(imm_instr(ALU_ADD, 3, 0, 1));
        prog.push_back(imm_instr(ALU_ADD, 4, 0, 2));
        prog.push_back(imm_instr(ALU_ADD, 5, 0, 3));
        prog.push_back(beq_instr(1, 3, 12));           // Not taken
        prog.push_back(imm_instr(ALU_ADD, 6, 0, 4));
        prog.push_back(imm_instr(ALU_ADD, 7, 6, 5));
        prog.push_back(beq_instr(7, 7, 8));
        prog.push_back(imm_instr(ALU_ADD, 1, 0, 9));
        prog.push_back(imm_instr(ALU_ADD, 2, 0, 10));
        run_program("branch_flush");
    endtask

    task automatic jal_link();
        prog.delete();
        prog.push_back(imm_instr(ALU_ADD, 1, 0, 1));
        prog.push_back(jal_instr(5, 12));              // Jumps to 16 and links 8 into x5
        prog.push_back(imm_instr(ALU_ADD, 2, 0, 2));
        prog.push_back(imm_instr(ALU_ADD, 3, 0, 3));
        prog.push_back(imm_instr(ALU_ADD, 4, 5, 0));
        prog.push_back(jal_instr(0, 8));
        prog.push_back(imm_instr(ALU_ADD, 6, 0, 6));
        prog.push_back(imm_instr(ALU_ADD, 7, 0, 7));
        run_program("jal_link");
    endtask

    task automatic random_alu();
        word_t   rnd;
        alu_op_e op;
        int      rd;
        int      rs1;
        int      rs2;
        prog.delete();
        for (int r = 1; r < 8; r++) begin
            rnd = next_rand();
            prog.push_back(imm_instr(ALU_ADD, r, 0, int'(rnd[27:16])));
        end
        for (int n = 0; n < 50; n++) begin
            rnd = next_rand();
            rd  = 1 + int'(rnd[31:16]) % 7;
            rs1 = 1 + int'(rnd[26:20]) % 7;
            rs2 = 1 + int'(rnd[23:17]) % 7;
            case (int'(rnd[29:22]) % 5)
                0:       op = ALU_ADD;
                1:       op = ALU_SUB;
                2:       op = ALU_AND;
                3:       op = ALU_OR;
                default: op = ALU_SLT;
            endcase
            if (rnd[30]) begin
                prog.push_back(reg_instr(op, rd, rs1, rs2));
            end else begin
                rnd = next_rand();
                if (op == ALU_SUB) begin
                    op = ALU_ADD;  // No immediate subtract in RV32I
                end
                prog.push_back(imm_instr(op, rd, rs1, int'(rnd[27:16])));
            end
        end
        run_program("random_alu");
    endtask

    initial begin
        rst = 1'b1;
        for (int i = 0; i < 256; i++) begin
            imem[i] = NOP;
        end
        alu_forwarding();
        load_store_stall();
        branch_flush();
        jal_link();
        random_alu();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== src/rv_core.sv ====
`timescale 1ns/1ps

module rv_core
    import rv_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    output word_t     imem_addr,
    input  word_t     imem_data,
    output logic      wb_valid,
    output reg_addr_t wb_rd,
    output word_t     wb_data
);

    word_t               instr_d, pc_d, pc4_d;
    reg_addr_t           rs1_d, rs2_d;
    logic                reg_write_e, mem_write_e, branch_e, jump_e, alu_src_e;
    rv_pkg::result_src_e result_src_e;
    rv_pkg::alu_op_e     alu_op_e;
    word_t               rd1_e, rd2_e, imm_e, pc_e, pc4_e;
    reg_addr_t           rd_e, rs1_e, rs2_e;
    logic                redirect, is_load_e;
    word_t               target;
    word_t               alu_m, store_data_m, pc4_m;
    reg_addr_t           rd_m;
    logic                reg_write_m, mem_write_m;
    rv_pkg::result_src_e result_src_m;
    fwd_sel_e            fwd_a, fwd_b;
    logic                stall_f, stall_d, flush_d, flush_e;

    rv_fetch u_fetch (
        .clk (clk), .rst (rst),
        .stall_f (stall_f), .stall_d (stall_d), .flush_d (flush_d),
        .redirect (redirect), .target (target),
        .imem_addr (imem_addr), .imem_data (imem_data),
        .instr_d (instr_d), .pc_d (pc_d), .pc4_d (pc4_d)
    );

    rv_decode u_decode (
        .clk (clk), .rst (rst), .flush_e (flush_e),
        .instr_d (instr_d), .pc_d (pc_d), .pc4_d (pc4_d),
        .wb_valid (wb_valid), .wb_rd (wb_rd), .wb_data (wb_data),
        .rs1_d (rs1_d), .rs2_d (rs2_d),
        .reg_write_e (reg_write_e), .mem_write_e (mem_write_e),
        .branch_e (branch_e), .jump_e (jump_e), .alu_src_e (alu_src_e),
        .result_src_e (result_src_e), .alu_op_e (alu_op_e),
        .rd1_e (rd1_e), .rd2_e (rd2_e), .imm_e (imm_e), .pc_e (pc_e), .pc4_e (pc4_e),
        .rd_e (rd_e), .rs1_e (rs1_e), .rs2_e (rs2_e)
    );

    rv_execute u_execute (
        .clk (clk), .rst (rst),
        .reg_write_e (reg_write_e), .mem_write_e (mem_write_e),
        .branch_e (branch_e), .jump_e (jump_e), .alu_src_e (alu_src_e),
        .result_src_e (result_src_e), .alu_op_e (alu_op_e),
        .rd1_e (rd1_e), .rd2_e (rd2_e), .imm_e (imm_e), .pc_e (pc_e), .pc4_e (pc4_e),
        .rd_e (rd_e), .fwd_a (fwd_a), .fwd_b (fwd_b), .wb_data (wb_data),
        .redirect (redirect), .target (target), .is_load_e (is_load_e),
        .alu_m (alu_m), .store_data_m (store_data_m), .rd_m (rd_m),
        .reg_write_m (reg_write_m), .mem_write_m (mem_write_m),
        .result_src_m (result_src_m), .pc4_m (pc4_m)
    );

    rv_memstage u_memstage (
        .clk (clk), .rst (rst),
        .alu_m (alu_m), .store_data_m (store_data_m), .rd_m (rd_m),
        .reg_write_m (reg_write_m), .mem_write_m (mem_write_m),
        .result_src_m (result_src_m), .pc4_m (pc4_m),
        .wb_valid (wb_valid), .wb_rd (wb_rd), .wb_data (wb_data)
    );

    rv_hazard u_hazard (
        .rs1_d (rs1_d), .rs2_d (rs2_d), .rs1_e (rs1_e), .rs2_e (rs2_e),
        .rd_e (rd_e), .is_load_e (is_load_e), .redirect (redirect),
        .rd_m (rd_m), .reg_write_m (reg_write_m),
        .wb_valid (wb_valid), .wb_rd (wb_rd),
        .fwd_a (fwd_a), .fwd_b (fwd_b),
        .stall_f (stall_f), .stall_d (stall_d), .flush_d (flush_d), .flush_e (flush_e)
    );

endmodule

// ==== src/rv_hazard.sv ====
`timescale 1ns/1ps

module rv_hazard
    import rv_pkg::*;
(
    input  reg_addr_t rs1_d,
    input  reg_addr_t rs2_d,
    input  reg_addr_t rs1_e,
    input  reg_addr_t rs2_e,
    input  reg_addr_t rd_e,
    input  logic      is_load_e,
    input  logic      redirect,
    input  reg_addr_t rd_m,
    input  logic      reg_write_m,
    input  logic      wb_valid,
    input  reg_addr_t wb_rd,
    output fwd_sel_e  fwd_a,
    output fwd_sel_e  fwd_b,
    output logic      stall_f,
    output logic      stall_d,
    output logic      flush_d,
    output logic      flush_e
);

    logic lw_stall;

    // Youngest producer wins
    function automatic fwd_sel_e pick_src(input reg_addr_t rs);
        if (reg_write_m && rd_m != '0 && rd_m == rs) begin
            return FWD_MEM;
        end
        if (wb_valid && wb_rd != '0 && wb_rd == rs) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    always_comb begin
        fwd_a = pick_src(rs1_e);
        fwd_b = pick_src(rs2_e);
    end

    assign lw_stall = is_load_e && (rd_e != '0) && ((rd_e == rs1_d) || (rd_e == rs2_d));

    assign stall_f = lw_stall;
    assign stall_d = lw_stall;
    assign flush_d = redirect;
    assign flush_e = lw_stall | redirect; // Bubble into execute

endmodule

// ==== src/rv_memstage.sv ====
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_memstage
    import rv_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  word_t       alu_m,
    input  word_t       store_data_m,
    input  reg_addr_t   rd_m,
    input  logic        reg_write_m,
    input  logic        mem_write_m,
    input  result_src_e result_src_m,
    input  word_t       pc4_m,
    output logic        wb_valid,
    output reg_addr_t   wb_rd,
    output word_t       wb_data
);

    localparam int AW = $clog2(`DMEM_WORDS);

    word_t       dmem [`DMEM_WORDS];
    logic [AW-1:0] dmem_idx;
    word_t       load_data;
    result_src_e result_src_w;
    word_t       alu_w;
    word_t       mem_w;
    word_t       pc4_w;

    assign dmem_idx  = alu_m[AW+1:2]; // Word addressed
    assign load_data = dmem[dmem_idx];

    always_ff @(posedge clk) begin
        if (mem_write_m) begin
            dmem[dmem_idx] <= store_data_m;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= reg_write_m && (rd_m != '0);
        end
    end

    always_ff @(posedge clk) begin
        result_src_w <= result_src_m;
        alu_w        <= alu_m;
        mem_w        <= load_data;
        pc4_w        <= pc4_m;
        wb_rd        <= rd_m;
    end

    always_comb begin
        case (result_src_w)
            RES_MEM: wb_data = mem_w;
            RES_PC4: wb_data = pc4_w; // JAL link
            default: wb_data = alu_w;
        endcase
    end

endmodule

// ==== src/rv_execute.sv ====
`timescale 1ns/1ps

module rv_execute
    import rv_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                reg_write_e,
    input  logic                mem_write_e,
    input  logic                branch_e,
    input  logic                jump_e,
    input  logic                alu_src_e,
    input  rv_pkg::result_src_e result_src_e,
    input  rv_pkg::alu_op_e     alu_op_e,
    input  word_t               rd1_e,
    input  word_t               rd2_e,
    input  word_t               imm_e,
    input  word_t               pc_e,
    input  word_t               pc4_e,
    input  reg_addr_t           rd_e,
    input  fwd_sel_e            fwd_a,
    input  fwd_sel_e            fwd_b,
    input  word_t               wb_data,
    output logic                redirect,
    output word_t               target,
    output logic                is_load_e,
    output word_t               alu_m,
    output word_t               store_data_m,
    output reg_addr_t           rd_m,
    output logic                reg_write_m,
    output logic                mem_write_m,
    output rv_pkg::result_src_e result_src_m,
    output word_t               pc4_m
);

    word_t src_a;
    word_t src_b_reg;
    word_t src_b;
    word_t alu_y;
    logic  zero;

    // alu_m is the registered result of the instruction now in memory
    function automatic word_t fwd_mux(input fwd_sel_e sel, input word_t reg_val);
        case (sel)
            FWD_MEM: return alu_m;
            FWD_WB:  return wb_data;
            default: return reg_val;
        endcase
    endfunction

    always_comb begin
        src_a     = fwd_mux(fwd_a, rd1_e);
        src_b_reg = fwd_mux(fwd_b, rd2_e);
        src_b     = alu_src_e ? imm_e : src_b_reg;
    end

    always_comb begin
        case (alu_op_e)
            ALU_SUB: alu_y = src_a - src_b;
            ALU_AND: alu_y = src_a & src_b;
            ALU_OR:  alu_y = src_a | src_b;
            ALU_SLT: alu_y = word_t'($signed(src_a) < $signed(src_b));
            default: alu_y = src_a + src_b;
        endcase
    end

    assign zero      = (alu_y == '0);
    assign redirect  = jump_e | (branch_e & zero);
    assign target    = pc_e + imm_e;
    assign is_load_e = (result_src_e == RES_MEM);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            reg_write_m  <= 1'b0;
            mem_write_m  <= 1'b0;
            result_src_m <= RES_ALU;
        end else begin
            reg_write_m  <= reg_write_e;
            mem_write_m  <= mem_write_e;
            result_src_m <= result_src_e;
        end
    end

    always_ff @(posedge clk) begin
        alu_m        <= alu_y;
        store_data_m <= src_b_reg; // Forwarded rs2 for SW
        rd_m         <= rd_e;
        pc4_m        <= pc4_e;
    end

endmodule

// ==== src/rv_decode.sv ====
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_decode
    import rv_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                flush_e,
    input  word_t               instr_d,
    input  word_t               pc_d,
    input  word_t               pc4_d,
    input  logic                wb_valid,
    input  reg_addr_t           wb_rd,
    input  word_t               wb_data,
    output reg_addr_t           rs1_d,
    output reg_addr_t           rs2_d,
    output logic                reg_write_e,
    output logic                mem_write_e,
    output logic                branch_e,
    output logic                jump_e,
    output logic                alu_src_e,
    output rv_pkg::result_src_e result_src_e,
    output rv_pkg::alu_op_e     alu_op_e,
    output word_t               rd1_e,
    output word_t               rd2_e,
    output word_t               imm_e,
    output word_t               pc_e,
    output word_t               pc4_e,
    output reg_addr_t           rd_e,
    output reg_addr_t           rs1_e,
    output reg_addr_t           rs2_e
);

    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic                funct7_5;
    logic                reg_write;
    logic                mem_write;
    logic                branch;
    logic                jump;
    logic                alu_src;
    logic                alu_arith;
    rv_pkg::result_src_e result_src;
    rv_pkg::alu_op_e     alu_op;
    imm_src_e            imm_src;
    word_t               imm;
    word_t               rd1;
    word_t               rd2;

    assign opcode   = instr_d[6:0];
    assign funct3   = instr_d[14:12];
    assign funct7_5 = instr_d[30];
    assign rs1_d    = instr_d[19:15];
    assign rs2_d    = instr_d[24:20];

    rv_regfile u_regfile (
        .clk   (clk),
        .rst   (rst),
        .rs1   (rs1_d),
        .rs2   (rs2_d),
        .rd1   (rd1),
        .rd2   (rd2),
        .we    (wb_valid),
        .waddr (wb_rd),
        .wdata (wb_data)
    );

    always_comb begin
        reg_write  = 1'b0;
        mem_write  = 1'b0;
        branch     = 1'b0;
        jump       = 1'b0;
        alu_src    = 1'b0;
        alu_arith  = 1'b0;
        result_src = RES_ALU;
        imm_src    = IMM_I;
        case (opcode)
            `OP_RTYPE: begin
                reg_write = 1'b1;
                alu_arith = 1'b1;
            end
            `OP_ITYPE: begin
                reg_write = 1'b1;
                alu_src   = 1'b1;
                alu_arith = 1'b1;
            end
            `OP_LOAD: begin
                reg_write  = 1'b1;
                alu_src    = 1'b1;
                result_src = RES_MEM;
            end
            `OP_STORE: begin
                mem_write = 1'b1;
                alu_src   = 1'b1;
                imm_src   = IMM_S;
            end
            `OP_BRANCH: begin
                branch  = 1'b1;
                imm_src = IMM_B;
            end
            `OP_JAL: begin
                reg_write  = 1'b1;
                jump       = 1'b1;
                result_src = RES_PC4;
                imm_src    = IMM_J;
            end
            default: ; // Unknown opcode retires as a bubble
        endcase
    end

    always_comb begin
        alu_op = ALU_ADD; // Address calc for LW/SW
        if (branch) begin
            alu_op = ALU_SUB; // BEQ compares through zero
        end else if (alu_arith) begin
            case (funct3)
                3'b000:  alu_op = (opcode == `OP_RTYPE && funct7_5) ? ALU_SUB : ALU_ADD;
                3'b010:  alu_op = ALU_SLT;
                3'b110:  alu_op = ALU_OR;
                3'b111:  alu_op = ALU_AND;
                default: alu_op = ALU_ADD;
            endcase
        end
    end

    always_comb begin
        case (imm_src)
            IMM_S:   imm = {{20{instr_d[31]}}, instr_d[31:25], instr_d[11:7]};
            IMM_B:   imm = {{20{instr_d[31]}}, instr_d[7], instr_d[30:25], instr_d[11:8], 1'b0};
            IMM_J:   imm = {{12{instr_d[31]}}, instr_d[19:12], instr_d[20], instr_d[30:21], 1'b0};
            default: imm = {{20{instr_d[31]}}, instr_d[31:20]};
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            reg_write_e  <= 1'b0;
            mem_write_e  <= 1'b0;
            branch_e     <= 1'b0;
            jump_e       <= 1'b0;
            result_src_e <= RES_ALU;
        end else begin
            reg_write_e  <= reg_write & ~flush_e;
            mem_write_e  <= mem_write & ~flush_e;
            branch_e     <= branch & ~flush_e;
            jump_e       <= jump & ~flush_e;
            result_src_e <= flush_e ? RES_ALU : result_src; // Bubble is never a load
        end
    end

    always_ff @(posedge clk) begin
        alu_src_e <= alu_src;
        alu_op_e  <= alu_op;
        rd1_e     <= rd1;
        rd2_e     <= rd2;
        imm_e     <= imm;
        pc_e      <= pc_d;
        pc4_e     <= pc4_d;
        rd_e      <= instr_d[11:7];
        rs1_e     <= rs1_d;
        rs2_e     <= rs2_d;
    end

endmodule

// ==== src/rv_regfile.sv ====
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_regfile
    import rv_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    output word_t     rd1,
    output word_t     rd2,
    input  logic      we,
    input  reg_addr_t waddr,
    input  word_t     wdata
);

    word_t regs [`NUM_REGS];

    // x0 is hardwired, a write in flight bypasses the array
    function automatic word_t read_port(input reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (we && waddr == addr) begin
            return wdata;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rd1 = read_port(rs1);
        rd2 = read_port(rs2);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

endmodule

// ==== src/rv_fetch.sv ====
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_fetch
    import rv_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  stall_f,
    input  logic  stall_d,
    input  logic  flush_d,
    input  logic  redirect,
    input  word_t target,
    output word_t imem_addr,
    input  word_t imem_data,
    output word_t instr_d,
    output word_t pc_d,
    output word_t pc4_d
);

    localparam word_t NOP = {12'd0, 5'd0, 3'd0, 5'd0, `OP_ITYPE}; // addi x0, x0, 0

    word_t pc;
    word_t pc4;

    assign pc4       = pc + word_t'(4);
    assign imem_addr = pc;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= '0;
        end else if (redirect) begin
            pc <= target;
        end else if (!stall_f) begin
            pc <= pc4;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            instr_d <= NOP;
        end else if (flush_d) begin
            instr_d <= NOP; // Wrong-path slot
        end else if (!stall_d) begin
            instr_d <= imem_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_d) begin
            pc_d  <= pc;
            pc4_d <= pc4;
        end
    end

endmodule

// ==== src/rv_pkg.sv ====
`include "rv_cfg.svh"

package rv_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [$clog2(`NUM_REGS)-1:0] reg_addr_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd5
    } alu_op_e;

    typedef enum logic [1:0] {
        RES_ALU = 2'd0,
        RES_MEM = 2'd1,
        RES_PC4 = 2'd2
    } result_src_e;

    typedef enum logic [1:0] {
        IMM_I = 2'd0,
        IMM_S = 2'd1,
        IMM_B = 2'd2,
        IMM_J = 2'd3
    } imm_src_e;

    // Operand source for the execute stage
    typedef enum logic [1:0] {
        FWD_REG = 2'd0,
        FWD_WB  = 2'd1,
        FWD_MEM = 2'd2
    } fwd_sel_e;

endpackage

// ==== src/rv_cfg.svh ====
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

`define XLEN       32
`define NUM_REGS   32
`define DMEM_WORDS 256

// RV32I major opcodes
`define OP_RTYPE  7'b0110011
`define OP_ITYPE  7'b0010011
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_BRANCH 7'b1100011
`define OP_JAL    7'b1101111

`endif
